// ==== build.f ====
params.sv
types.sv
command_decoder.sv
control_cmd_readframe.sv
frame_buffer.sv
panel_scanner.sv
led_panel_top.sv
tb_led_panel.sv

// ==== command_decoder.sv ====
/* host byte stream parser, no back-pressure. a load command always takes the
   next FRAME_BYTES bytes as payload, whatever their values. */
`timescale 1ns/1ps

module command_decoder (
    input  logic clk,
    input  logic reset,
    input  logic [7:0] rx_byte,
    input  logic rx_valid,
    output logic [7:0] frame_byte,
    output logic frame_byte_valid,
    output logic blank
);

    typedef enum logic [1:0] {
        ST_COMMAND,
        ST_FRAME,
        ST_BLANK_ARG
    } dec_state_t;

    dec_state_t state;
    logic [params::FRAME_ADDR_W-1:0] byte_count;   // payload bytes taken so far.

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_COMMAND;
            byte_count <= '0;
            frame_byte_valid <= 1'b0;
            blank <= 1'b0;
        end else begin
            frame_byte_valid <= 1'b0;
            if (rx_valid) begin
                case (state)
                    ST_COMMAND: begin
                        if (rx_byte == params::CMD_LOAD_FRAME) begin
                            state <= ST_FRAME;
                            byte_count <= '0;
                        end else if (rx_byte == params::CMD_SET_BLANK) begin
                            state <= ST_BLANK_ARG;
                        end
                        // anything else is dropped.
                    end
                    ST_FRAME: begin
                        frame_byte_valid <= 1'b1;
                        if (byte_count == params::FRAME_LAST) begin
                            state <= ST_COMMAND;
                        end else begin
                            byte_count <= byte_count + 1'b1;
                        end
                    end
                    ST_BLANK_ARG: begin
                        blank <= (rx_byte != 8'h00);
                        state <= ST_COMMAND;
                    end
                    default: state <= ST_COMMAND;
                endcase
            end
        end
    end

    // payload register, qualified by frame_byte_valid.
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            frame_byte <= rx_byte;
        end
    end

endmodule

// ==== control_cmd_readframe.sv ====
/* frame writer. bytes are stored from the last address down to 0,0,0, so the
   host sends the frame in reverse order. one write per enabled byte. */
`timescale 1ns/1ps

module control_cmd_readframe (
    input  logic clk,
    input  logic reset,
    input  logic [7:0] frame_byte,
    input  logic enable,
    output types::ram_wr_t wr,
    output logic done
);

    typedef enum logic [1:0] {
        ST_PRIME,
        ST_COUNT,
        ST_DONE
    } wr_state_t;

    wr_state_t state;
    types::frame_addr_t addr;        // address of the last byte written.
    types::frame_addr_t addr_next;
    types::frame_addr_t top_addr;

    always_comb begin
        top_addr.row = types::row_addr_t'(params::PIXEL_HEIGHT - 1);
        top_addr.col = types::col_addr_t'(params::PIXEL_WIDTH - 1);
        top_addr.pixel = types::pixel_addr_t'(params::BYTES_PER_PIXEL - 1);
    end

    // count down pixel, then column, then row.
    always_comb begin
        addr_next = addr;
        if (addr.pixel != '0) begin
            addr_next.pixel = addr.pixel - 1'b1;
        end else begin
            addr_next.pixel = top_addr.pixel;
            if (addr.col != '0) begin
                addr_next.col = addr.col - 1'b1;
            end else begin
                addr_next.col = top_addr.col;
                addr_next.row = addr.row - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_PRIME;
            addr <= '0;
            wr.valid <= 1'b0;
            done <= 1'b0;
        end else begin
            wr.valid <= 1'b0;
            done <= 1'b0;
            case (state)
                ST_PRIME: begin
                    if (enable) begin
                        addr <= top_addr;   // first byte goes to the top.
                        wr.addr <= top_addr;
                        wr.data <= frame_byte;
                        wr.valid <= 1'b1;
                        state <= ST_COUNT;
                    end
                end
                ST_COUNT: begin
                    if (enable) begin
                        addr <= addr_next;
                        wr.addr <= addr_next;
                        wr.data <= frame_byte;
                        wr.valid <= 1'b1;
                        if (addr_next == '0) begin
                            state <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    done <= 1'b1;   // cycle after the final write.
                    state <= ST_PRIME;
                end
                default: state <= ST_PRIME;
            endcase
        end
    end

endmodule

// ==== frame_buffer.sv ====
/* single-frame byte store. the read is registered; a read of the address
   being written in the same cycle returns the old byte. */
`timescale 1ns/1ps

module frame_buffer (
    input  logic clk,
    input  types::ram_wr_t wr,
    input  types::frame_addr_t rd_addr,
    output logic [7:0] rd_data
);

    logic [7:0] mem [params::FRAME_BYTES];

    logic [params::FRAME_ADDR_W-1:0] wr_index;
    logic [params::FRAME_ADDR_W-1:0] rd_index;

    // (row * width + col) * bytes per pixel + pixel.
    function automatic logic [params::FRAME_ADDR_W-1:0] lin_index(
        input types::frame_addr_t a
    );
        int idx;
        idx = (int'(a.row) * params::PIXEL_WIDTH + int'(a.col)) * params::BYTES_PER_PIXEL;
        idx = idx + int'(a.pixel);
        return params::FRAME_ADDR_W'(idx);
    endfunction

    assign wr_index = lin_index(wr.addr);
    assign rd_index = lin_index(rd_addr);

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            mem[wr_index] <= wr.data;
        end
        rd_data <= mem[rd_index];   // old data on a collision.
    end

endmodule

// ==== led_panel_top.sv ====
/* LED panel controller top. frame_loaded pulses three cycles after the
   strobe of the last payload byte. */
`timescale 1ns/1ps

module led_panel_top (
    input  logic clk,
    input  logic reset,
    input  logic [7:0] rx_byte,
    input  logic rx_valid,
    output types::pixel_word_t pixel_out,
    output logic pixel_valid,
    output logic frame_loaded
);

    logic [7:0] frame_byte;
    logic frame_byte_valid;
    logic blank;
    types::ram_wr_t wr;
    types::frame_addr_t rd_addr;
    logic [7:0] rd_data;

    command_decoder decoder_i (
        .clk              (clk),
        .reset            (reset),
        .rx_byte          (rx_byte),
        .rx_valid         (rx_valid),
        .frame_byte       (frame_byte),
        .frame_byte_valid (frame_byte_valid),
        .blank            (blank)
    );

    control_cmd_readframe writer_i (
        .clk        (clk),
        .reset      (reset),
        .frame_byte (frame_byte),
        .enable     (frame_byte_valid),
        .wr         (wr),
        .done       (frame_loaded)
    );

    frame_buffer buffer_i (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    panel_scanner scanner_i (
        .clk         (clk),
        .reset       (reset),
        .blank       (blank),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .pixel_out   (pixel_out),
        .pixel_valid (pixel_valid)
    );

endmodule

// ==== panel_scanner.sv ====
/* free-running scan, one pixel every BYTES_PER_PIXEL cycles from 0,0 upward.
   blank zeroes the colours only, positions keep advancing. */
`timescale 1ns/1ps

module panel_scanner (
    input  logic clk,
    input  logic reset,
    input  logic blank,
    output types::frame_addr_t rd_addr,
    input  logic [7:0] rd_data,
    output types::pixel_word_t pixel_out,
    output logic pixel_valid
);

    types::frame_addr_t scan_addr;   // address issued this cycle.
    types::frame_addr_t addr_d;      // address matching rd_data.
    logic addr_d_valid;
    logic [7:0] red_hold;
    logic [7:0] green_hold;

    assign rd_addr = scan_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            scan_addr.row <= '0;
            scan_addr.col <= '0;
            scan_addr.pixel <= types::pixel_addr_t'(params::BYTES_PER_PIXEL - 1);
            addr_d_valid <= 1'b0;
            pixel_valid <= 1'b0;
        end else begin
            addr_d_valid <= 1'b1;
            pixel_valid <= addr_d_valid && (addr_d.pixel == '0);
            if (scan_addr.pixel != '0) begin
                scan_addr.pixel <= scan_addr.pixel - 1'b1;
            end else begin
                scan_addr.pixel <= types::pixel_addr_t'(params::BYTES_PER_PIXEL - 1);
                if (scan_addr.col == types::col_addr_t'(params::PIXEL_WIDTH - 1)) begin
                    scan_addr.col <= '0;
                    if (scan_addr.row == types::row_addr_t'(params::PIXEL_HEIGHT - 1)) begin
                        scan_addr.row <= '0;
                    end else begin
                        scan_addr.row <= scan_addr.row + 1'b1;
                    end
                end else begin
                    scan_addr.col <= scan_addr.col + 1'b1;
                end
            end
        end
    end

    // gather colour bytes, emit when blue arrives.
    always_ff @(posedge clk) begin
        addr_d <= scan_addr;
        case (addr_d.pixel)
            types::pixel_addr_t'(2): red_hold <= rd_data;
            types::pixel_addr_t'(1): green_hold <= rd_data;
            types::pixel_addr_t'(0): begin
                pixel_out.row <= addr_d.row;
                pixel_out.col <= addr_d.col;
                pixel_out.red <= blank ? 8'h00 : red_hold;
                pixel_out.green <= blank ? 8'h00 : green_hold;
                pixel_out.blue <= blank ? 8'h00 : rd_data;
            end
            default: ;
        endcase
    end

endmodule

// ==== params.sv ====
/* panel geometry and host command codes. each dimension must be at least 2
   so that every index type below gets one or more bits. */
package params;

    localparam int PIXEL_WIDTH = 4;       // columns per row.
    localparam int PIXEL_HEIGHT = 2;      // rows.
    localparam int BYTES_PER_PIXEL = 3;   // byte 2 red, 1 green, 0 blue.

    localparam int FRAME_BYTES = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;
    localparam int FRAME_ADDR_W = $clog2(FRAME_BYTES);   // linear buffer index.
    localparam logic [FRAME_ADDR_W-1:0] FRAME_LAST = FRAME_ADDR_W'(FRAME_BYTES - 1);

    // host command bytes.
    localparam logic [7:0] CMD_LOAD_FRAME = 8'h01;   // followed by FRAME_BYTES bytes.
    localparam logic [7:0] CMD_SET_BLANK = 8'h02;    // followed by one argument byte.

endpackage

// ==== run.sh ====
#!/bin/sh
# Compile and run the LED panel testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    --top-module tb_led_panel \
    -f build.f \
    --Mdir obj_dir \
    -o sim_led_panel

./obj_dir/sim_led_panel > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
exit 0

// ==== tb_led_panel.sv ====
/* drives host bytes into led_panel_top and checks full panel scans against
   a reference model. frames are sent highest address first. */
`timescale 1ns/1ps

module tb_led_panel;

    localparam int LOAD_TIMEOUT = 60;      // cycles to wait for frame_loaded.
    localparam int LOAD_LATENCY = 3;       // last payload strobe to frame_loaded.
    localparam int PIXEL_TIMEOUT = 60;     // cycles to wait for one pixel strobe.
    localparam int SCAN_TIMEOUT = 80;      // cycles to collect one full scan.
    localparam int SCAN_PIXELS = params::PIXEL_WIDTH * params::PIXEL_HEIGHT;

    logic clk;
    logic reset;
    logic [7:0] rx_byte;
    logic rx_valid;
    types::pixel_word_t pixel_out;
    logic pixel_valid;
    logic frame_loaded;

    logic [7:0] sent_frame [params::FRAME_BYTES];   // bytes in the order sent.
    logic [7:0] exp_frame [params::FRAME_BYTES];
    logic [15:0] lfsr_state;
    types::pixel_word_t exp_word;
    bit checking;
    bit exp_blank;
    bit reset_check;
    string phase;
    int checked_count = 0;
    int total_pixels = 0;
    int error_count = 0;
    int timeout_count;

    led_panel_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .pixel_out    (pixel_out),
        .pixel_valid  (pixel_valid),
        .frame_loaded (frame_loaded)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois form with taps 16,14,13,11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    function automatic int draw_bits(input int nbits);
        int value;
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    // first byte sent lands at the highest linear address.
    function automatic types::pixel_word_t expected_pixel(
        input logic [7:0] frame [params::FRAME_BYTES],
        input int row,
        input int col,
        input bit blanked
    );
        types::pixel_word_t w;
        int base;
        base = (row * params::PIXEL_WIDTH + col) * params::BYTES_PER_PIXEL;
        w.row = types::row_addr_t'(row);
        w.col = types::col_addr_t'(col);
        w.red = frame[params::FRAME_BYTES - 1 - (base + 2)];
        w.green = frame[params::FRAME_BYTES - 1 - (base + 1)];
        w.blue = frame[params::FRAME_BYTES - 1 - base];
        if (blanked) begin
            w.red = 8'h00;
            w.green = 8'h00;
            w.blue = 8'h00;
        end
        return w;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    // compares pixel strobes on the rising edge.
    always @(posedge clk) begin
        if (reset_check) begin
            check_value("pixel_valid around reset", 32'(pixel_valid), 32'd0);
            check_value("frame_loaded around reset", 32'(frame_loaded), 32'd0);
        end
        if (!checking) begin
            checked_count = 0;
        end else if (pixel_valid) begin
            exp_word = expected_pixel(exp_frame,
                                      (checked_count / params::PIXEL_WIDTH) % params::PIXEL_HEIGHT,
                                      checked_count % params::PIXEL_WIDTH, exp_blank);
            check_value({phase, " position"}, 32'({pixel_out.row, pixel_out.col}),
                        32'({exp_word.row, exp_word.col}));
            check_value({phase, " colour"},
                        32'({pixel_out.red, pixel_out.green, pixel_out.blue}),
                        32'({exp_word.red, exp_word.green, exp_word.blue}));
            checked_count++;
            total_pixels++;
        end
    end

    // starts and returns on a falling edge.
    task automatic send_byte(input logic [7:0] value, input int gap);
        rx_byte = value;
        rx_valid = 1'b1;
        @(negedge clk);
        rx_valid = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic send_frame(input bit with_gaps);
        int gap;
        send_byte(params::CMD_LOAD_FRAME, 0);
        for (int i = 0; i < params::FRAME_BYTES; i++) begin
            sent_frame[i] = 8'(draw_bits(8));
            gap = (with_gaps && i != params::FRAME_BYTES - 1) ? draw_bits(3) : 0;
            send_byte(sent_frame[i], gap);
        end
    endtask

    // entered on the falling edge that ends the last payload strobe.
    task automatic wait_frame_loaded();
        int cycles;
        bit seen;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < LOAD_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            seen = frame_loaded;
        end
        if (!seen) begin
            timeout_count++;
            $display("timeout: frame_loaded never pulsed during %s", phase);
        end else begin
            check_value({phase, " frame_loaded latency"}, 32'(cycles + 1),
                        32'(LOAD_LATENCY));
            @(negedge clk);
            check_value({phase, " frame_loaded pulse width"}, 32'(frame_loaded), 32'd0);
        end
    endtask

    task automatic wait_pixel(input bit any_pos, input int row, input int col);
        int cycles;
        bit seen;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < PIXEL_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (pixel_valid && (any_pos || (int'(pixel_out.row) == row
                                            && int'(pixel_out.col) == col))) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            timeout_count++;
            $display("timeout: no pixel strobe seen during %s", phase);
        end
    endtask

    // skip pixels that may hold old data, then check one scan from 0,0.
    task automatic scan_and_compare();
        int cycles;
        wait_pixel(1'b1, 0, 0);
        wait_pixel(1'b1, 0, 0);
        wait_pixel(1'b0, params::PIXEL_HEIGHT - 1, params::PIXEL_WIDTH - 1);
        @(negedge clk);
        checking = 1'b1;
        cycles = 0;
        while (checked_count < SCAN_PIXELS && cycles < SCAN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (checked_count < SCAN_PIXELS) begin
            timeout_count++;
            $display("timeout: only %0d pixels collected during %s", checked_count, phase);
        end
        checking = 1'b0;
    endtask

    initial begin
        rx_byte = 8'h00;
        rx_valid = 1'b0;
        reset = 1'b1;
        checking = 1'b0;
        exp_blank = 1'b0;
        reset_check = 1'b0;
        timeout_count = 0;
        lfsr_state = 16'd95;
        phase = "reset";
        @(negedge clk);
        reset_check = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        repeat (2) @(negedge clk);
        reset_check = 1'b0;

        phase = "first frame";
        send_frame(1'b0);
        wait_frame_loaded();
        exp_frame = sent_frame;
        scan_and_compare();

        phase = "frame with gaps";
        send_frame(1'b1);
        wait_frame_loaded();
        exp_frame = sent_frame;
        scan_and_compare();

        phase = "frame after unknown command";
        send_byte(8'hA5, 0);
        send_frame(1'b0);
        wait_frame_loaded();
        exp_frame = sent_frame;
        scan_and_compare();

        phase = "blanked panel";
        send_byte(params::CMD_SET_BLANK, 0);
        send_byte(8'(draw_bits(8)) | 8'h01, 0);
        exp_blank = 1'b1;
        scan_and_compare();

        phase = "unblanked panel";
        send_byte(params::CMD_SET_BLANK, 0);
        send_byte(8'h00, 0);
        exp_blank = 1'b0;
        scan_and_compare();

        repeat (2) @(negedge clk);
        $display("pixels checked: %0d, mismatches: %0d, timeouts: %0d",
                 total_pixels, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== types.sv ====
/* address, buffer write and pixel structs. index widths follow the geometry
   in params, so a dimension of 1 is not supported. */
package types;

    typedef logic [$clog2(params::PIXEL_HEIGHT)-1:0] row_addr_t;
    typedef logic [$clog2(params::PIXEL_WIDTH)-1:0] col_addr_t;
    typedef logic [$clog2(params::BYTES_PER_PIXEL)-1:0] pixel_addr_t;

    // one byte position in the frame.
    typedef struct packed {
        row_addr_t row;
        col_addr_t col;
        pixel_addr_t pixel;
    } frame_addr_t;

    // frame buffer write, valid for a single cycle per byte.
    typedef struct packed {
        frame_addr_t addr;
        logic [7:0] data;
        logic valid;
    } ram_wr_t;

    // one scanned pixel with its position.
    typedef struct packed {
        row_addr_t row;
        col_addr_t col;
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_word_t;

endpackage
